// File: source/icache_pkg.sv
package icache_pkg;

    // fetch address and instruction sizes
    localparam int ADDR_W = 32;
    localparam int WORD_W = 32;

    // 4 KiB per way with 16-byte lines
    localparam int WORDS_PER_LINE = 4;
    localparam int LINE_W = WORDS_PER_LINE * WORD_W; // 128
    localparam int SETS = 256;
    localparam int WAYS = 2;

    // address split
    localparam int OFFSET_W = $clog2(LINE_W / 8); // byte offset bits in a line
    localparam int INDEX_W = $clog2(SETS); // 8
    localparam int TAG_W = ADDR_W - INDEX_W - OFFSET_W; // 20

    typedef logic [WORD_W-1:0] word_t;

    // word 0 sits in the low bits as in the memory return
    typedef word_t [WORDS_PER_LINE-1:0] line_t;

    typedef struct packed {
        logic [TAG_W-1:0] tag;
        logic valid;
    } tag_entry_t;

    // tag, index, offset in address order
    typedef struct packed {
        logic [TAG_W-1:0] tag;
        logic [INDEX_W-1:0] index;
        logic [OFFSET_W-1:0] offset;
    } fetch_req_t;

    typedef struct packed {
        word_t insn;
        logic hit; // answered without a refill
    } fetch_resp_t;

    // line address with the offset dropped
    typedef struct packed {
        logic [TAG_W-1:0] tag;
        logic [INDEX_W-1:0] index;
    } mem_req_t;

    // controller states
    typedef enum logic [2:0] {
        S_IDLE,
        S_LOOKUP,
        S_MISS_REQ,
        S_REFILL,
        S_RESPOND
    } ctrl_state_t;

endpackage

// File: source/way_ram.sv
module way_ram #(
    parameter type entry_t = logic [31:0],
    parameter int DEPTH = 256
) (
    input logic clk,
    input logic we,
    input logic [$clog2(DEPTH)-1:0] addr,
    input entry_t wdata,
    output entry_t rdata
);

    // one entry per set
    entry_t mem [DEPTH];

    // single port
    // read returns the old entry when the same address is written
    always_ff @(posedge clk) begin
        if (we) begin
            mem[addr] <= wdata;
        end
        rdata <= mem[addr]; // registered read, one cycle latency
    end

endmodule

// File: source/lru_state.sv
module lru_state (
    input logic clk,
    input logic reset,
    input logic [icache_pkg::INDEX_W-1:0] index,
    input logic touch, // hit used a way
    input logic fill, // refill wrote a way
    input logic way,
    output logic victim_way
);

    import icache_pkg::*;

    // bit set means way 1 is least recently used
    logic [SETS-1:0] lru_q;

    always_ff @(posedge clk) begin
        if (reset) begin
            lru_q <= '0;
        end else if (touch || fill) begin
            lru_q[index] <= ~way; // the other way is now the older one
        end
    end

    // combinational lookup for the buffered set
    assign victim_way = lru_q[index];

    // controller never hits and refills in the same cycle
    a_touch_fill_excl: assert property (
        @(posedge clk) disable iff (reset)
        !(touch && fill)
    ) else $error("lru_state: touch and fill together");

endmodule

// File: source/icache_ctrl.sv
module icache_ctrl (
    input logic clk,
    input logic reset,

    // fetch side
    input logic req_valid,
    output logic req_ready,
    input icache_pkg::fetch_req_t req,
    output logic resp_valid,
    input logic resp_ready,
    output icache_pkg::fetch_resp_t resp,

    // memory side
    output logic mem_req_valid,
    input logic mem_req_ready,
    output icache_pkg::mem_req_t mem_req,
    input logic mem_ret_valid,
    input icache_pkg::line_t mem_ret_data,

    // storage
    output logic [icache_pkg::INDEX_W-1:0] ram_index,
    output logic [icache_pkg::WAYS-1:0] tag_we,
    output icache_pkg::tag_entry_t tag_wdata,
    input icache_pkg::tag_entry_t [icache_pkg::WAYS-1:0] tag_rdata,
    output logic [icache_pkg::WAYS-1:0] data_we,
    output icache_pkg::line_t data_wdata,
    input icache_pkg::line_t [icache_pkg::WAYS-1:0] data_rdata,

    // replacement
    output logic lru_touch,
    output logic lru_fill,
    output logic lru_way,
    input logic victim_way
);

    import icache_pkg::*;

    ctrl_state_t state_q;
    ctrl_state_t state_n;

    fetch_req_t buf_q; // the single outstanding request
    fetch_resp_t resp_q;
    logic ready_q;

    // valid bits live here so the tag RAMs need no clearing sweep
    logic [SETS-1:0][WAYS-1:0] valid_q;

    tag_entry_t [WAYS-1:0] tag_view;
    logic [WAYS-1:0] hit;
    logic hit_any;
    logic hit_way;
    logic [OFFSET_W-3:0] word_sel;
    logic accept;
    logic refill_done;

    assign accept = req_valid && req_ready;
    assign refill_done = (state_q == S_REFILL) && mem_ret_valid;
    assign word_sel = buf_q.offset[OFFSET_W-1:2]; // drop byte bits

    // tag compare against the valid bits of the register array
    always_comb begin
        for (int w = 0; w < WAYS; w++) begin
            tag_view[w].tag = tag_rdata[w].tag;
            tag_view[w].valid = valid_q[buf_q.index][w];
            hit[w] = tag_view[w].valid && (tag_view[w].tag == buf_q.tag);
        end
    end

    assign hit_any = |hit;
    assign hit_way = hit[1];

    // next state
    always_comb begin
        state_n = state_q;
        case (state_q)
            S_IDLE: if (accept) state_n = S_LOOKUP;
            S_LOOKUP: state_n = hit_any ? S_RESPOND : S_MISS_REQ;
            S_MISS_REQ: if (mem_req_ready) state_n = S_REFILL;
            S_REFILL: if (mem_ret_valid) state_n = S_RESPOND;
            S_RESPOND: if (resp_ready) state_n = S_IDLE;
            default: state_n = S_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state_q <= S_IDLE;
            ready_q <= 1'b0;
            valid_q <= '0;
        end else begin
            state_q <= state_n;
            ready_q <= (state_n == S_IDLE); // low while a request is in flight
            if (refill_done) begin
                valid_q[buf_q.index][victim_way] <= 1'b1;
            end
        end
    end

    // payload registers
    always_ff @(posedge clk) begin
        if (accept) begin
            buf_q <= req;
        end
        if (state_q == S_LOOKUP && hit_any) begin
            resp_q.insn <= data_rdata[hit_way][word_sel];
            resp_q.hit <= 1'b1;
        end else if (refill_done) begin
            resp_q.insn <= mem_ret_data[word_sel]; // answer from the returned line
            resp_q.hit <= 1'b0;
        end
    end

    assign req_ready = ready_q;
    assign resp_valid = (state_q == S_RESPOND);
    assign resp = resp_q;

    assign mem_req_valid = (state_q == S_MISS_REQ);
    assign mem_req.tag = buf_q.tag;
    assign mem_req.index = buf_q.index;

    // incoming index while idle so lookup has data one cycle later
    assign ram_index = (state_q == S_IDLE) ? req.index : buf_q.index;

    // refill goes into the victim way
    always_comb begin
        tag_we = '0;
        data_we = '0;
        if (refill_done) begin
            tag_we[victim_way] = 1'b1;
            data_we[victim_way] = 1'b1;
        end
    end

    assign tag_wdata.tag = buf_q.tag;
    assign tag_wdata.valid = 1'b1;
    assign data_wdata = mem_ret_data;

    assign lru_touch = (state_q == S_LOOKUP) && hit_any;
    assign lru_fill = refill_done;
    assign lru_way = lru_fill ? victim_way : hit_way;

    // response held under back-pressure
    a_resp_stable: assert property (
        @(posedge clk) disable iff (reset)
        resp_valid && !resp_ready |=> resp_valid && $stable(resp)
    ) else $error("icache_ctrl: resp changed while stalled");

    // memory request held until taken
    a_mem_req_stable: assert property (
        @(posedge clk) disable iff (reset)
        mem_req_valid && !mem_req_ready |=> mem_req_valid && $stable(mem_req)
    ) else $error("icache_ctrl: mem_req changed while stalled");

    // a line never lives in both ways
    a_hit_onehot: assert property (
        @(posedge clk) disable iff (reset)
        (state_q == S_LOOKUP) |-> $onehot0(hit)
    ) else $error("icache_ctrl: more than one way hit");

endmodule

// File: source/icache_top.sv
module icache_top (
    input logic clk,
    input logic reset,

    input logic req_valid,
    output logic req_ready,
    input icache_pkg::fetch_req_t req,

    output logic resp_valid,
    input logic resp_ready,
    output icache_pkg::fetch_resp_t resp,

    output logic mem_req_valid,
    input logic mem_req_ready,
    output icache_pkg::mem_req_t mem_req,

    input logic mem_ret_valid,
    input icache_pkg::line_t mem_ret_data
);

    import icache_pkg::*;

    logic [INDEX_W-1:0] ram_index;
    logic [WAYS-1:0] tag_we;
    logic [WAYS-1:0] data_we;
    tag_entry_t tag_wdata;
    tag_entry_t [WAYS-1:0] tag_rdata;
    line_t data_wdata;
    line_t [WAYS-1:0] data_rdata;
    logic lru_touch;
    logic lru_fill;
    logic lru_way;
    logic victim_way;

    icache_ctrl u_ctrl (
        .clk (clk),
        .reset (reset),
        .req_valid (req_valid),
        .req_ready (req_ready),
        .req (req),
        .resp_valid (resp_valid),
        .resp_ready (resp_ready),
        .resp (resp),
        .mem_req_valid (mem_req_valid),
        .mem_req_ready (mem_req_ready),
        .mem_req (mem_req),
        .mem_ret_valid (mem_ret_valid),
        .mem_ret_data (mem_ret_data),
        .ram_index (ram_index),
        .tag_we (tag_we),
        .tag_wdata (tag_wdata),
        .tag_rdata (tag_rdata),
        .data_we (data_we),
        .data_wdata (data_wdata),
        .data_rdata (data_rdata),
        .lru_touch (lru_touch),
        .lru_fill (lru_fill),
        .lru_way (lru_way),
        .victim_way (victim_way)
    );

    // one tag RAM and one data RAM per way
    for (genvar w = 0; w < WAYS; w++) begin : g_way
        way_ram #(
            .entry_t (tag_entry_t),
            .DEPTH (SETS)
        ) u_tag_ram (
            .clk (clk),
            .we (tag_we[w]),
            .addr (ram_index),
            .wdata (tag_wdata),
            .rdata (tag_rdata[w])
        );

        way_ram #(
            .entry_t (line_t),
            .DEPTH (SETS)
        ) u_data_ram (
            .clk (clk),
            .we (data_we[w]),
            .addr (ram_index),
            .wdata (data_wdata),
            .rdata (data_rdata[w])
        );
    end

    lru_state u_lru (
        .clk (clk),
        .reset (reset),
        .index (ram_index), // buffered index outside idle
        .touch (lru_touch),
        .fill (lru_fill),
        .way (lru_way),
        .victim_way (victim_way)
    );

endmodule

// File: test/refill_memory.sv
module refill_memory (
    input logic clk,
    input logic reset,
    input logic mem_req_valid,
    output logic mem_req_ready,
    input icache_pkg::mem_req_t mem_req,
    output logic mem_ret_valid,
    output icache_pkg::line_t mem_ret_data
);

    timeunit 1ns;
    timeprecision 100ps;

    import icache_pkg::*;

    logic ready_q = 1'b0;
    logic ret_valid_q = 1'b0;
    line_t ret_data_q = '0;
    logic busy = 1'b0; // a line read is in flight
    mem_req_t line_q;
    int stall_left = 0;
    int delay_left = 0;

    // each word holds its word address times an odd constant
    function automatic line_t line_at(input mem_req_t la);
        line_t l;
        for (int i = 0; i < WORDS_PER_LINE; i++) begin
            l[i] = word_t'({la, 2'(i)}) * 32'h9E37_79B1;
        end
        return l;
    endfunction

    always @(posedge clk) begin
        ret_valid_q <= 1'b0; // return is a single-cycle pulse
        if (reset) begin
            ready_q <= 1'b0;
            busy <= 1'b0;
            stall_left <= 0;
        end else if (busy) begin
            if (delay_left == 0) begin
                ret_valid_q <= 1'b1;
                ret_data_q <= line_at(line_q);
                busy <= 1'b0;
            end else begin
                delay_left <= delay_left - 1;
            end
        end else if (mem_req_valid && ready_q) begin
            line_q <= mem_req;
            ready_q <= 1'b0;
            busy <= 1'b1;
            delay_left <= $urandom_range(5, 0); // line comes back 1 to 6 cycles later
        end else if (mem_req_valid) begin
            if (stall_left == 0) begin
                ready_q <= 1'b1;
            end else begin
                stall_left <= stall_left - 1;
            end
        end else begin
            stall_left <= $urandom_range(3, 0); // stall for the next request
        end
    end

    assign mem_req_ready = ready_q;
    assign mem_ret_valid = ret_valid_q;
    assign mem_ret_data = ret_data_q;

endmodule

// File: test/icache_tb.sv
module icache_tb;

    timeunit 1ns;
    timeprecision 100ps;

    import icache_pkg::*;

    localparam int TIMEOUT = 100; // cycles allowed per wait
    localparam int ROWS = 13;

    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        int stall; // cycles resp_ready stays low
    } stim_t;

    // fetch address, resp_ready stall
    stim_t stim [ROWS] = '{
        '{32'h0000_1040, 0}, // cold miss in set 0x04
        '{32'h0000_1044, 0},
        '{32'h0000_1048, 0},
        '{32'h0000_104C, 0},
        '{32'h0001_0200, 0}, // tag A in set 0x20
        '{32'h0002_0204, 0}, // tag B
        '{32'h0001_0208, 0}, // A hits
        '{32'h0003_020C, 0}, // C evicts B
        '{32'h0002_0200, 0}, // B evicts A
        '{32'h0003_0204, 5}, // hit held back
        '{32'h0040_0010, 3}, // miss held back
        '{32'h0040_001C, 2},
        '{32'h0000_1040, 0}  // first line still resident
    };

    logic clk;
    logic reset;
    logic req_valid;
    logic req_ready;
    fetch_req_t req;
    logic resp_valid;
    logic resp_ready;
    fetch_resp_t resp;
    logic mem_req_valid;
    logic mem_req_ready;
    mem_req_t mem_req;
    logic mem_ret_valid;
    line_t mem_ret_data;

    // reference cache state
    logic [TAG_W-1:0] model_tag [SETS][WAYS];
    logic model_valid [SETS][WAYS];
    logic model_lru [SETS]; // names the victim way

    mem_req_t seen_reqs [$];
    int returns = 0;
    int errors = 0;
    int checks = 0;
    int tests = 0;
    int failed_tests = 0;
    logic timed_out = 1'b0;

    icache_top DUT (.*);

    refill_memory u_mem (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // record memory traffic as it happens
    always @(posedge clk) begin
        if (mem_req_valid && mem_req_ready) seen_reqs.push_back(mem_req);
        if (mem_ret_valid) returns++;
    end

    function automatic word_t expected_word(input fetch_req_t r);
        return word_t'({r.tag, r.index, r.offset[OFFSET_W-1:2]}) * 32'h9E37_79B1;
    endfunction

    function automatic fetch_resp_t predict_and_update(input fetch_req_t r);
        fetch_resp_t p;
        logic victim;
        p.insn = expected_word(r);
        p.hit = 1'b0;
        for (int w = 0; w < WAYS; w++) begin
            if (model_valid[r.index][w] && model_tag[r.index][w] == r.tag) begin
                p.hit = 1'b1;
                model_lru[r.index] = (w == 0); // other way gets older
            end
        end
        if (!p.hit) begin
            victim = model_lru[r.index];
            model_tag[r.index][victim] = r.tag;
            model_valid[r.index][victim] = 1'b1;
            model_lru[r.index] = !victim;
        end
        return p;
    endfunction

    task automatic check_resp(input fetch_resp_t got, input fetch_resp_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Fail at %0t ns: resp insn %h hit %b, expected insn %h hit %b",
                $time, got.insn, got.hit, exp.insn, exp.hit);
        end
    endtask

    task automatic check_mem_req(input mem_req_t got, input mem_req_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Fail at %0t ns: mem_req tag %h index %h, expected tag %h index %h",
                $time, got.tag, got.index, exp.tag, exp.index);
        end
    endtask

    task automatic check_flag(input string what, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Fail at %0t ns: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    task automatic check_count(input string what, input int got, input int exp);
        checks++;
        if (got != exp) begin
            errors++;
            $display("Fail at %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic run_fetch(input int row);
        fetch_req_t r;
        fetch_resp_t exp;
        fetch_resp_t first;
        mem_req_t exp_line;
        int n_reqs;
        int n_rets;
        int errs_before;
        int waited;
        r = stim[row].addr;
        errs_before = errors;
        exp = predict_and_update(r);
        exp_line.tag = r.tag;
        exp_line.index = r.index;
        n_reqs = seen_reqs.size();
        n_rets = returns;
        tests++;

        req <= r;
        req_valid <= 1'b1;
        waited = 0;
        do begin
            @(posedge clk);
            waited++;
        end while (!req_ready && waited < TIMEOUT);
        if (!req_ready) begin
            $display("Timeout: fetch of %h was never accepted", r);
            errors++;
            failed_tests++;
            timed_out = 1'b1;
            return;
        end
        req_valid <= 1'b0;

        waited = 0;
        do begin
            @(posedge clk);
            waited++;
        end while (!resp_valid && waited < TIMEOUT);
        if (!resp_valid) begin
            $display("Timeout: no response for fetch of %h", r);
            errors++;
            failed_tests++;
            timed_out = 1'b1;
            return;
        end

        first = resp;
        check_resp(resp, exp);
        if (exp.hit) begin
            check_count("memory requests", seen_reqs.size() - n_reqs, 0);
            check_count("edges to response", waited, 2); // valid from the edge after accept
        end else begin
            check_count("memory requests", seen_reqs.size() - n_reqs, 1);
            check_count("lines returned", returns - n_rets, 1);
            if (seen_reqs.size() > n_reqs) check_mem_req(seen_reqs[n_reqs], exp_line);
        end

        // response has to sit still while the requester stalls
        for (int k = 0; k < stim[row].stall; k++) begin
            @(posedge clk);
            check_resp(resp, first);
            check_flag("resp_valid under stall", resp_valid, 1'b1);
            check_flag("req_ready under stall", req_ready, 1'b0);
        end
        resp_ready <= 1'b1;
        @(posedge clk);
        check_flag("resp_valid at transfer", resp_valid, 1'b1);
        resp_ready <= 1'b0;
        @(posedge clk);
        check_flag("req_ready after transfer", req_ready, 1'b1);

        if (errors != errs_before) failed_tests++;
        $display("test %0d: fetch %h hit %b %s", row, r, exp.hit,
            (errors == errs_before) ? "ok" : "mismatch");
    endtask

    initial begin
        void'($urandom(98)); // single seed for the memory delays
        reset = 1'b1;
        req_valid = 1'b0;
        req = '0;
        resp_ready = 1'b0;
        foreach (model_valid[s, w]) model_valid[s][w] = 1'b0;
        foreach (model_lru[s]) model_lru[s] = 1'b0;

        repeat (16) @(posedge clk);
        reset <= 1'b0;
        repeat (2) @(posedge clk);
        tests++;
        check_flag("req_ready after reset", req_ready, 1'b1);
        check_flag("resp_valid after reset", resp_valid, 1'b0);
        check_flag("mem_req_valid after reset", mem_req_valid, 1'b0);
        if (errors != 0) failed_tests++;
        $display("test reset: %s", (errors == 0) ? "ok" : "mismatch");

        for (int i = 0; i < ROWS && !timed_out; i++) begin
            run_fetch(i);
        end

        $display("%0d tests, %0d with errors, %0d checks, %0d errors",
            tests, failed_tests, checks, errors);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

// File: files.f
source/icache_pkg.sv
source/way_ram.sv
source/lru_state.sv
source/icache_ctrl.sv
source/icache_top.sv
test/refill_memory.sv
test/icache_tb.sv

// File: Makefile
# Verilator build for the instruction cache testbench

VERILATOR ?= verilator
TOP ?= icache_tb
FILELIST ?= files.f
OBJ_DIR ?= obj_dir
VFLAGS ?= --timing --assert
BUILD_JOBS ?= 0

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

# pass only if the run prints the pass line
sim:
	$(VERILATOR) --binary -j $(BUILD_JOBS) $(VFLAGS) -f $(FILELIST) \
		--top-module $(TOP) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Regression passed"

clean:
	rm -rf $(OBJ_DIR)
